// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ctrl_top_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/ctrl_top_tb.sv ====
// Randomized testbench for ctrl_top with two chip selects sharing one slave model.
// Expected MOSI bytes, received bytes and STATUS come from queues kept in this bench.
`timescale 1ns/1ps

module ctrl_top_tb;

    import ctrl_pkg::*;

    localparam int FIFO_DEPTH      = 16;
    localparam int MAX_DIV         = 63;
    localparam int RAND_ROUNDS     = 4;
    localparam int RAND_BYTES      = 6;
    localparam int HOLD_BYTES      = 5;
    localparam int OVF_BYTES       = 20;
    localparam int NUM_BYTES       = RAND_ROUNDS * RAND_BYTES + HOLD_BYTES + OVF_BYTES
                                   + FIFO_DEPTH + 1;
    localparam int WATCHDOG_CYCLES = 2 * NUM_BYTES * 16 * (MAX_DIV + 1) + 5000;
    localparam logic [31:0] REG_UNMAPPED = 32'h10;

    logic       clk;
    logic       rst_n;
    axil_req_t  req;
    axil_rsp_t  rsp;
    logic       spi_clk;
    logic       spi_mosi;
    logic       spi_miso;
    logic [1:0] spi_cs_n;

    logic [7:0] miso_ref [$];
    logic [7:0] exp_mosi [$];
    logic [7:0] model_rx [$];
    logic       model_ovf;
    int         sent_count;

    ctrl_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .AXIL_ADDR_WIDTH(32),
        .AXIL_DATA_WIDTH(32),
        .SPI_CS_WIDTH   (2)
    ) uut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .axil_req_i(req),
        .axil_rsp_o(rsp),
        .spi_clk_o (spi_clk),
        .spi_mosi_o(spi_mosi),
        .spi_miso_i(spi_miso),
        .spi_cs_n_o(spi_cs_n)
    );

    spi_slave_model slave (
        .spi_clk_i (spi_clk),
        .spi_cs_n_i(&spi_cs_n),  // either select addresses the same model.
        .spi_mosi_i(spi_mosi),
        .spi_miso_o(spi_miso)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: SPI transfers did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_rsp(string name, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rx(string name, spi_rx_t got, spi_rx_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got.data, exp.data);
            abort_run();
        end
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // every bus task starts and returns 1 ns after a rising edge.
    task automatic axil_write(logic [31:0] addr, logic [31:0] data, output logic [1:0] resp);
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hF;
        do begin
            @(posedge clk);
            #1;
        end while (!rsp.bvalid);
        resp        = rsp.bresp;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
    endtask

    task automatic axil_read(logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        req.arvalid = 1'b1;
        req.araddr  = addr;
        do begin
            @(posedge clk);
            #1;
        end while (!rsp.rvalid);
        data        = rsp.rdata;
        resp        = rsp.rresp;
        req.arvalid = 1'b0;
    endtask

    task automatic write_ok(logic [31:0] addr, logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_rsp("bresp", resp, RESP_OKAY);
    endtask

    task automatic queue_byte(logic hold, logic sel, logic [1:0] exp_resp);
        logic [7:0] data;
        logic [1:0] resp;
        data = 8'($urandom);
        axil_write(REG_TXDATA, {22'b0, sel, hold, data}, resp);
        check_rsp("bresp", resp, exp_resp);
        if (exp_resp == RESP_OKAY) begin
            exp_mosi.push_back(data);  // a dropped byte must never reach MOSI.
        end
    endtask

    function automatic logic [31:0] status_word(logic busy, logic full);
        return {16'(sent_count), 8'(model_rx.size()), 5'b0, model_ovf, full, busy};
    endfunction

    task automatic check_mosi();
        spi_rx_t got;
        spi_rx_t exp;
        check_word("mosi_count", 32'(slave.mosi_bytes.size()), 32'(exp_mosi.size()));
        foreach (exp_mosi[i]) begin
            got.data = slave.mosi_bytes[i];
            exp.data = exp_mosi[i];
            check_rx("spi_mosi", got, exp);
        end
    endtask

    // wait for the engine to finish, then update the receive model.
    task automatic settle(int target);
        logic [31:0] word;
        logic [1:0]  resp;
        do begin
            axil_read(REG_STATUS, word, resp);
        end while (word[31:16] != 16'(target) || word[0]);
        for (int i = sent_count; i < target; i++) begin
            if (model_rx.size() < FIFO_DEPTH) begin
                model_rx.push_back(miso_ref[i]);
            end else begin
                model_ovf = 1'b1;
            end
        end
        sent_count = target;
        check_mosi();
        axil_read(REG_STATUS, word, resp);
        check_rsp("rresp", resp, RESP_OKAY);
        check_word("status", word, status_word(1'b0, 1'b0));
    endtask

    task automatic drain_rx();
        logic [31:0] word;
        logic [1:0]  resp;
        spi_rx_t     got;
        spi_rx_t     exp;
        while (model_rx.size() > 0) begin
            axil_read(REG_RXDATA, word, resp);
            check_rsp("rresp", resp, RESP_OKAY);
            check_word("rxdata_flags", word >> 8, 32'h1);  // valid bit only.
            got.data = word[7:0];
            exp.data = model_rx.pop_front();
            check_rx("rxdata", got, exp);
        end
        axil_read(REG_RXDATA, word, resp);
        check_rsp("rresp", resp, RESP_OKAY);
        check_word("rxdata_empty", word, 32'h0);
    endtask

    initial begin
        logic [31:0] word;
        logic [1:0]  resp;
        logic        sel;
        logic [1:0]  exp_cs;
        logic        seen_low;
        int          target;

        void'($urandom(24519));
        rst_n      = 1'b0;
        req        = '0;
        req.bready = 1'b1;
        req.rready = 1'b1;
        model_ovf  = 1'b0;
        sent_count = 0;
        for (int i = 0; i < NUM_BYTES + 8; i++) begin
            miso_ref.push_back(8'($urandom));
            slave.miso_bytes.push_back(miso_ref[i]);
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset state.
        check_word("spi_cs_n", 32'(spi_cs_n), 32'h3);
        check_word("bvalid", 32'(rsp.bvalid), 32'h0);
        check_word("rvalid", 32'(rsp.rvalid), 32'h0);
        check_word("ready", 32'(rsp.awready & rsp.wready & rsp.arready), 32'h1);
        axil_read(REG_STATUS, word, resp);
        check_rsp("rresp", resp, RESP_OKAY);
        check_word("status", word, 32'h0);

        // random bytes and dividers, receive FIFO read every second round.
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            write_ok(REG_CTRL, $urandom % 8);
            for (int i = 0; i < RAND_BYTES; i++) begin
                queue_byte(1'b0, 1'($urandom), RESP_OKAY);
            end
            settle(sent_count + RAND_BYTES);
            if (r % 2 == 1) begin
                drain_rx();
            end
        end

        // held sequence on one select.
        write_ok(REG_CTRL, 32'd3);
        sel    = 1'($urandom);
        exp_cs = sel ? 2'b01 : 2'b10;
        target = sent_count + HOLD_BYTES;
        for (int i = 0; i < HOLD_BYTES; i++) begin
            queue_byte(i < HOLD_BYTES - 1, sel, RESP_OKAY);
        end
        seen_low = 1'b0;
        while (slave.mosi_bytes.size() < target) begin
            if (spi_cs_n != 2'b11) begin
                seen_low = 1'b1;
            end
            check_word("spi_cs_n", 32'(spi_cs_n), seen_low ? 32'(exp_cs) : 32'h3);
            @(posedge clk);
            #1;
        end
        settle(target);
        drain_rx();

        // receive overflow with no reads in between.
        write_ok(REG_CTRL, 32'd0);
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < OVF_BYTES / 2; i++) begin
                queue_byte(1'b0, 1'($urandom), RESP_OKAY);
            end
            settle(sent_count + OVF_BYTES / 2);
        end
        axil_read(REG_STATUS, word, resp);
        check_word("status_ovf", 32'(word[2]), 32'h1);
        check_word("rx_count", 32'(word[15:8]), 32'(FIFO_DEPTH));
        write_ok(REG_STATUS, 32'h4);
        model_ovf = 1'b0;
        axil_read(REG_STATUS, word, resp);
        check_word("status", word, status_word(1'b0, 1'b0));
        drain_rx();

        // unmapped address and a full command FIFO.
        axil_write(REG_UNMAPPED, 32'hFFFF_FFFF, resp);
        check_rsp("bresp", resp, RESP_SLVERR);
        axil_read(REG_UNMAPPED, word, resp);
        check_rsp("rresp", resp, RESP_SLVERR);
        check_word("rdata", word, 32'h0);
        axil_read(REG_CTRL, word, resp);
        check_word("ctrl", word, 32'h0);
        write_ok(REG_CTRL, 32'(MAX_DIV));
        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            queue_byte(1'b0, 1'($urandom), (i <= FIFO_DEPTH) ? RESP_OKAY : RESP_SLVERR);
        end
        axil_read(REG_STATUS, word, resp);
        check_word("status_full_busy", 32'(word[1:0]), 32'h3);
        settle(sent_count + FIFO_DEPTH + 1);
        drain_rx();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== bench/spi_slave_model.sv ====
// Behavioral SPI mode 0 slave. Bytes are counted over all transfers, so MISO byte n
// answers the n-th byte on the bus. Past the preset bytes it returns zeros.
`timescale 1ns/1ps

module spi_slave_model (
    input  logic spi_clk_i,
    input  logic spi_cs_n_i,
    input  logic spi_mosi_i,
    output logic spi_miso_o
);

    logic [7:0] miso_bytes [$];  // preset by the testbench.
    logic [7:0] mosi_bytes [$];  // one entry per finished byte.
    logic [7:0] shift_q;
    int         bit_cnt;
    int         byte_idx;

    function automatic logic miso_bit(int idx, int pos);
        logic [7:0] b;
        b = (idx < miso_bytes.size()) ? miso_bytes[idx] : 8'h00;
        return b[7 - pos];
    endfunction

    initial begin
        spi_miso_o = 1'b0;
        shift_q    = '0;
        bit_cnt    = 0;
        byte_idx   = 0;
        forever begin
            @(posedge spi_clk_i or negedge spi_clk_i or negedge spi_cs_n_i);
            if (spi_cs_n_i === 1'b0) begin
                if (spi_clk_i === 1'b1) begin
                    shift_q = {shift_q[6:0], spi_mosi_i};  // sample on rising sclk.
                    bit_cnt++;
                    if (bit_cnt == 8) begin
                        mosi_bytes.push_back(shift_q);
                        bit_cnt = 0;
                        byte_idx++;
                    end
                end else begin
                    spi_miso_o = miso_bit(byte_idx, bit_cnt);  // falling sclk or cs fall.
                end
            end
        end
    end

endmodule

// ==== filelist.f ====
logic/ctrl_pkg.sv
logic/sync_fifo.sv
logic/axil_reg_decode.sv
logic/spi_shift_engine.sv
logic/spi_result_collect.sv
logic/ctrl_top.sv
bench/spi_slave_model.sv
bench/ctrl_top_tb.sv

// ==== logic/axil_reg_decode.sv ====
// AXI-Lite slave for the SPI bridge registers. One outstanding write and one read.
// wstrb is ignored. AXIL_DATA_WIDTH must be 32 and AXIL_ADDR_WIDTH at least 4.
`timescale 1ns/1ps

module axil_reg_decode #(
    parameter int AXIL_ADDR_WIDTH = 32,
    parameter int AXIL_DATA_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  ctrl_pkg::axil_req_t   axil_req_i,
    output ctrl_pkg::axil_rsp_t   axil_rsp_o,
    output logic                  cmd_push_o,
    output ctrl_pkg::spi_cmd_t    cmd_data_o,
    input  logic                  cmd_full_i,
    output ctrl_pkg::spi_ctrl_t   spi_ctrl_o,
    output logic                  rx_pop_o,
    input  ctrl_pkg::spi_rx_t     rx_data_i,
    input  logic                  rx_empty_i,
    input  logic [7:0]            rx_count_i,
    input  logic [15:0]           xfer_count_i,
    input  logic                  overflow_i,
    output logic                  ovf_clear_o,
    input  logic                  busy_i
);

    import ctrl_pkg::*;

    logic [AXIL_ADDR_WIDTH-1:0] wr_addr;
    logic [AXIL_ADDR_WIDTH-1:0] rd_addr;
    logic                       wr_fire;
    logic                       rd_fire;
    logic                       wr_is_ctrl, wr_is_tx, wr_is_rx, wr_is_status;
    logic                       rd_is_ctrl, rd_is_tx, rd_is_rx, rd_is_status;
    logic                       wr_err;
    logic                       rd_err;
    logic [AXIL_DATA_WIDTH-1:0] rd_word;

    logic                       bvalid_q;
    logic [1:0]                 bresp_q;
    logic                       rvalid_q;
    logic [1:0]                 rresp_q;
    logic [AXIL_DATA_WIDTH-1:0] rdata_q;
    spi_ctrl_t                  ctrl_q;

    assign wr_addr = axil_req_i.awaddr[AXIL_ADDR_WIDTH-1:0];
    assign rd_addr = axil_req_i.araddr[AXIL_ADDR_WIDTH-1:0];

    // address and data must arrive together.
    assign wr_fire = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
    assign rd_fire = axil_req_i.arvalid & ~rvalid_q;

    assign wr_is_ctrl   = (wr_addr == AXIL_ADDR_WIDTH'(REG_CTRL));
    assign wr_is_tx     = (wr_addr == AXIL_ADDR_WIDTH'(REG_TXDATA));
    assign wr_is_rx     = (wr_addr == AXIL_ADDR_WIDTH'(REG_RXDATA));
    assign wr_is_status = (wr_addr == AXIL_ADDR_WIDTH'(REG_STATUS));
    assign rd_is_ctrl   = (rd_addr == AXIL_ADDR_WIDTH'(REG_CTRL));
    assign rd_is_tx     = (rd_addr == AXIL_ADDR_WIDTH'(REG_TXDATA));
    assign rd_is_rx     = (rd_addr == AXIL_ADDR_WIDTH'(REG_RXDATA));
    assign rd_is_status = (rd_addr == AXIL_ADDR_WIDTH'(REG_STATUS));

    assign wr_err = ~(wr_is_ctrl | wr_is_tx | wr_is_rx | wr_is_status)
                  | (wr_is_tx & cmd_full_i);  // full fifo drops the byte.
    assign rd_err = ~(rd_is_ctrl | rd_is_tx | rd_is_rx | rd_is_status);

    assign cmd_push_o  = wr_fire & wr_is_tx & ~cmd_full_i;
    assign cmd_data_o  = spi_cmd_t'(axil_req_i.wdata[9:0]);
    assign ovf_clear_o = wr_fire & wr_is_status & axil_req_i.wdata[2];
    assign rx_pop_o    = rd_fire & rd_is_rx & ~rx_empty_i;
    assign spi_ctrl_o  = ctrl_q;

    always_comb begin
        rd_word = '0;
        if (rd_is_ctrl) begin
            rd_word = AXIL_DATA_WIDTH'(ctrl_q.clk_div);
        end else if (rd_is_rx && !rx_empty_i) begin
            rd_word = AXIL_DATA_WIDTH'({1'b1, rx_data_i.data});  // bit 8 marks valid.
        end else if (rd_is_status) begin
            rd_word = AXIL_DATA_WIDTH'({xfer_count_i, rx_count_i, 5'b0,
                                        overflow_i, cmd_full_i, busy_i});
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (wr_fire && wr_is_ctrl) begin
            ctrl_q.clk_div <= axil_req_i.wdata[7:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end else if (axil_req_i.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            rresp_q  <= RESP_OKAY;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
            rresp_q  <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            rdata_q <= rd_word;
        end
    end

    assign axil_rsp_o.awready = ~bvalid_q;
    assign axil_rsp_o.wready  = ~bvalid_q;
    assign axil_rsp_o.bvalid  = bvalid_q;
    assign axil_rsp_o.bresp   = bresp_q;
    assign axil_rsp_o.arready = ~rvalid_q;
    assign axil_rsp_o.rvalid  = rvalid_q;
    assign axil_rsp_o.rdata   = rdata_q;
    assign axil_rsp_o.rresp   = rresp_q;

    // a write response is held with a stable code until the master takes it.
    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bvalid_q && !axil_req_i.bready |=> bvalid_q && $stable(bresp_q));

endmodule

// ==== logic/ctrl_pkg.sv ====
// Register map and bus/SPI payload types for the AXI-Lite to SPI bridge.
// Bus fields are fixed at 32 bits. spi_cmd_t carries a 1-bit cs_sel, so at most two slaves.
package ctrl_pkg;

    localparam logic [31:0] REG_CTRL   = 32'h0;  // clk_div in bits 7:0.
    localparam logic [31:0] REG_TXDATA = 32'h4;  // push one spi command.
    localparam logic [31:0] REG_RXDATA = 32'h8;  // pop one received byte.
    localparam logic [31:0] REG_STATUS = 32'hC;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    // field order matches TXDATA bits 9:0.
    typedef struct packed {
        logic       cs_sel;
        logic       hold;
        logic [7:0] data;
    } spi_cmd_t;

    typedef struct packed {
        logic [7:0] clk_div;  // half-period is clk_div+1 cycles.
    } spi_ctrl_t;

    typedef struct packed {
        logic [7:0] data;
    } spi_rx_t;

endpackage

// ==== logic/ctrl_top.sv ====
// AXI-Lite controlled SPI master: register decode, command FIFO, shift engine, receive side.
// Single clock domain; rst_n_i is synchronous to clk_i.
`timescale 1ns/1ps

module ctrl_top #(
    parameter int FIFO_DEPTH      = 16,
    parameter int AXIL_ADDR_WIDTH = 32,
    parameter int AXIL_DATA_WIDTH = 32,
    parameter int SPI_CS_WIDTH    = 1
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  ctrl_pkg::axil_req_t      axil_req_i,
    output ctrl_pkg::axil_rsp_t      axil_rsp_o,
    output logic                     spi_clk_o,
    output logic                     spi_mosi_o,
    input  logic                     spi_miso_i,
    output logic [SPI_CS_WIDTH-1:0]  spi_cs_n_o
);

    import ctrl_pkg::*;

    logic                        cmd_push, cmd_pop, cmd_full, cmd_empty;
    spi_cmd_t                    cmd_wr, cmd_rd;
    spi_ctrl_t                   spi_ctrl;
    logic                        busy, done;
    spi_rx_t                     rx_byte, rx_head;
    logic                        rx_pop, rx_empty, overflow, ovf_clear;
    logic [7:0]                  rx_count;
    logic [15:0]                 xfer_count;

    axil_reg_decode #(
        .AXIL_ADDR_WIDTH(AXIL_ADDR_WIDTH),
        .AXIL_DATA_WIDTH(AXIL_DATA_WIDTH)
    ) i_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .cmd_push_o  (cmd_push),
        .cmd_data_o  (cmd_wr),
        .cmd_full_i  (cmd_full),
        .spi_ctrl_o  (spi_ctrl),
        .rx_pop_o    (rx_pop),
        .rx_data_i   (rx_head),
        .rx_empty_i  (rx_empty),
        .rx_count_i  (rx_count),
        .xfer_count_i(xfer_count),
        .overflow_i  (overflow),
        .ovf_clear_o (ovf_clear),
        .busy_i      (busy)
    );

    sync_fifo #(
        .T    (spi_cmd_t),
        .DEPTH(FIFO_DEPTH)
    ) i_cmd_fifo (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .push_i (cmd_push),
        .data_i (cmd_wr),
        .pop_i  (cmd_pop),
        .data_o (cmd_rd),
        .empty_o(cmd_empty),
        .full_o (cmd_full),
        .count_o()
    );

    spi_shift_engine #(
        .SPI_CS_WIDTH(SPI_CS_WIDTH)
    ) i_execute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .cmd_i      (cmd_rd),
        .cmd_valid_i(~cmd_empty),
        .cmd_pop_o  (cmd_pop),
        .spi_ctrl_i (spi_ctrl),
        .busy_o     (busy),
        .done_o     (done),
        .rx_o       (rx_byte),
        .spi_clk_o  (spi_clk_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_miso_i (spi_miso_i),
        .spi_cs_n_o (spi_cs_n_o)
    );

    spi_result_collect #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_result (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .done_i      (done),
        .rx_i        (rx_byte),
        .pop_i       (rx_pop),
        .rx_data_o   (rx_head),
        .rx_empty_o  (rx_empty),
        .rx_count_o  (rx_count),
        .xfer_count_o(xfer_count),
        .overflow_o  (overflow),
        .ovf_clear_i (ovf_clear)
    );

endmodule

// ==== logic/spi_result_collect.sv ====
// Receive side. Bytes arriving on a full FIFO are dropped and set the sticky overflow.
// FIFO_DEPTH is limited to 128 so the fill count fits in 8 bits.
`timescale 1ns/1ps

module spi_result_collect #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               done_i,
    input  ctrl_pkg::spi_rx_t  rx_i,
    input  logic               pop_i,
    output ctrl_pkg::spi_rx_t  rx_data_o,
    output logic               rx_empty_o,
    output logic [7:0]         rx_count_o,
    output logic [15:0]        xfer_count_o,
    output logic               overflow_o,
    input  logic               ovf_clear_i
);

    import ctrl_pkg::*;

    logic                        rx_full;
    logic [$clog2(FIFO_DEPTH):0] fill;
    logic [15:0]                 xfer_q;
    logic                        ovf_q;

    sync_fifo #(
        .T    (spi_rx_t),
        .DEPTH(FIFO_DEPTH)
    ) i_rx_fifo (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .push_i (done_i & ~rx_full),
        .data_i (rx_i),
        .pop_i  (pop_i),
        .data_o (rx_data_o),
        .empty_o(rx_empty_o),
        .full_o (rx_full),
        .count_o(fill)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            xfer_q <= '0;
            ovf_q  <= 1'b0;
        end else begin
            if (done_i) xfer_q <= xfer_q + 16'd1;  // wraps at 65536.
            if (done_i && rx_full) begin
                ovf_q <= 1'b1;  // a new drop wins over a clear.
            end else if (ovf_clear_i) begin
                ovf_q <= 1'b0;
            end
        end
    end

    assign rx_count_o   = 8'(fill);
    assign xfer_count_o = xfer_q;
    assign overflow_o   = ovf_q;

endmodule

// ==== logic/spi_shift_engine.sv ====
// SPI mode 0 byte engine, MSB first. A held byte keeps chip select low into the next one.
// SPI_CS_WIDTH is 1 or 2; with one slave cs_sel is ignored.
`timescale 1ns/1ps

module spi_shift_engine #(
    parameter int SPI_CS_WIDTH = 1
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  ctrl_pkg::spi_cmd_t       cmd_i,
    input  logic                     cmd_valid_i,
    output logic                     cmd_pop_o,
    input  ctrl_pkg::spi_ctrl_t      spi_ctrl_i,
    output logic                     busy_o,
    output logic                     done_o,
    output ctrl_pkg::spi_rx_t        rx_o,
    output logic                     spi_clk_o,
    output logic                     spi_mosi_o,
    input  logic                     spi_miso_i,
    output logic [SPI_CS_WIDTH-1:0]  spi_cs_n_o
);

    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_SHIFT,
        ST_RELEASE
    } state_e;

    state_e     state_q;
    logic [7:0] div_q;
    logic [7:0] div_lim_q;
    logic       sclk_q;
    logic [2:0] bit_q;
    logic       cs_active_q;
    logic       done_q;
    logic       tick;
    logic [7:0] tx_q;
    logic [7:0] rx_q;
    logic       hold_q;
    logic       sel_q;

    assign tick      = (div_q == div_lim_q);  // one half-period elapsed.
    assign cmd_pop_o = (state_q == ST_IDLE) && cmd_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            div_q       <= '0;
            sclk_q      <= 1'b0;
            bit_q       <= '0;
            cs_active_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            div_q  <= tick ? 8'd0 : div_q + 8'd1;
            case (state_q)
                ST_IDLE: begin
                    if (cmd_valid_i) begin
                        cs_active_q <= 1'b1;  // falls during setup.
                        state_q     <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    div_q   <= '0;
                    bit_q   <= '0;
                    state_q <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    if (tick) begin
                        sclk_q <= ~sclk_q;
                        if (sclk_q) begin
                            bit_q <= bit_q + 3'd1;
                            if (bit_q == 3'd7) begin
                                done_q  <= 1'b1;
                                state_q <= hold_q ? ST_IDLE : ST_RELEASE;
                            end
                        end
                    end
                end
                ST_RELEASE: begin
                    if (tick) begin
                        cs_active_q <= 1'b0;
                        state_q     <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // shift registers and latched command fields.
    always_ff @(posedge clk_i) begin
        if (cmd_pop_o) begin
            tx_q      <= cmd_i.data;
            hold_q    <= cmd_i.hold;
            sel_q     <= cmd_i.cs_sel;
            div_lim_q <= spi_ctrl_i.clk_div;
        end else if (state_q == ST_SHIFT && tick) begin
            if (!sclk_q) begin
                rx_q <= {rx_q[6:0], spi_miso_i};  // sample on rising sclk.
            end else begin
                tx_q <= {tx_q[6:0], 1'b0};  // next bit on falling sclk.
            end
        end
    end

    always_comb begin
        for (int i = 0; i < SPI_CS_WIDTH; i++) begin
            spi_cs_n_o[i] = ~(cs_active_q && ((SPI_CS_WIDTH > 1) ? (int'(sel_q) == i) : 1'b1));
        end
    end

    assign spi_clk_o  = sclk_q;
    assign spi_mosi_o = tx_q[7];
    assign busy_o     = (state_q != ST_IDLE);
    assign done_o     = done_q;
    assign rx_o.data  = rx_q;

    a_cs_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(~spi_cs_n_o));

endmodule

// ==== logic/sync_fifo.sv ====
// Single-clock FIFO with show-ahead read data. DEPTH must be a power of two, at least 2.
// Callers must not push when full or pop when empty.
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     push_i,
    input  T                         data_i,
    input  logic                     pop_i,
    output T                         data_o,
    output logic                     empty_o,
    output logic                     full_o,
    output logic [$clog2(DEPTH):0]   count_o
);

    localparam int AW = $clog2(DEPTH);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at DEPTH.
            if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (AW+1)'(do_push) - (AW+1)'(do_pop);
        end
    end

    assign data_o  = mem[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (AW+1)'(DEPTH));
    assign count_o = count_q;

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o);

endmodule
